/* logic/rv_core_pkg.sv */
package rv_core_pkg;

    // ==================================================
    // Widths and flow control
    // ==================================================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int CREDIT_W   = 3;

    localparam logic [CREDIT_W-1:0] RESULT_CREDITS = 3'd4;  // Consumer slots at reset

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t PC_STEP = 32'd4;

    // ==================================================
    // Instruction field positions
    // ==================================================
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_W   = 3;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_B5  = 30;   // SUB / SRA select
    localparam int IMM_I_LSB  = 20;
    localparam int IMM_I_W    = 12;
    localparam int IMM_U_LSB  = 12;
    localparam int IMM_U_W    = 20;

    // funct3 codes of the OP / OP-IMM groups
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SR      = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // ==================================================
    // Encodings
    // ==================================================
    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_REG, SRC_A_PC, SRC_A_ZERO
    } src_a_e;

endpackage

/* logic/pipe_if.sv */
`timescale 1ns/1ps

// Decode to execute bundle
interface dec_exe_if;
    logic                  valid;
    logic                  illegal;
    rv_core_pkg::alu_op_e  alu_op;
    rv_core_pkg::src_a_e   src_a;
    logic                  use_imm;     // Operand B from immediate
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::reg_addr_t rs1;
    rv_core_pkg::reg_addr_t rs2;
    rv_core_pkg::word_t    rs1_data;
    rv_core_pkg::word_t    rs2_data;
    rv_core_pkg::word_t    imm;
    rv_core_pkg::word_t    pc;

    modport dec (
        output valid, illegal, alu_op, src_a, use_imm,
        output rd, rs1, rs2, rs1_data, rs2_data, imm, pc
    );

    modport exe (
        input valid, illegal, alu_op, src_a, use_imm,
        input rd, rs1, rs2, rs1_data, rs2_data, imm, pc
    );
endinterface

// Execute to result bundle
interface exe_res_if;
    logic                   valid;
    logic                   illegal;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::word_t     data;

    modport exe (
        output valid, illegal, rd, data
    );

    modport res (
        input valid, illegal, rd, data
    );
endinterface

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  rv_core_pkg::reg_addr_t raddr1_i,
    input  rv_core_pkg::reg_addr_t raddr2_i,
    output rv_core_pkg::word_t     rdata1_o,
    output rv_core_pkg::word_t     rdata2_o,
    input  logic                   wen_i,
    input  rv_core_pkg::reg_addr_t waddr_i,
    input  rv_core_pkg::word_t     wdata_i
);

    rv_core_pkg::word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-first read, a same-cycle write wins over the stored value
    always_comb begin
        if (raddr1_i == '0)                       rdata1_o = '0;
        else if (wen_i && waddr_i == raddr1_i)    rdata1_o = wdata_i;
        else                                      rdata1_o = regs[raddr1_i];
    end

    always_comb begin
        if (raddr2_i == '0)                       rdata2_o = '0;
        else if (wen_i && waddr_i == raddr2_i)    rdata2_o = wdata_i;
        else                                      rdata2_o = regs[raddr2_i];
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   instr_valid_i,
    input  rv_core_pkg::word_t     instr_i,
    input  logic                   credit_return_i,
    output logic                   instr_ready_o,
    dec_exe_if.dec                 exe_o,
    input  logic                   wb_en_i,
    input  rv_core_pkg::reg_addr_t wb_rd_i,
    input  rv_core_pkg::word_t     wb_data_i
);

    logic [rv_core_pkg::CREDIT_W-1:0] credit_q, credit_d;
    logic                 accept;
    logic                 valid_q;
    rv_core_pkg::word_t   instr_q;
    rv_core_pkg::word_t   pc_q, pc_cnt_q;
    rv_core_pkg::opcode_e opcode;
    logic [rv_core_pkg::FUNCT3_W-1:0] funct3;
    logic                 alt;
    rv_core_pkg::alu_op_e alu_f3;
    rv_core_pkg::word_t   imm_i, imm_u;

    // ==================================================
    // Admission credits and PC
    // ==================================================
    assign instr_ready_o = (credit_q != '0);
    assign accept        = instr_valid_i && instr_ready_o;

    always_comb begin
        credit_d = credit_q;
        if (accept && !credit_return_i)
            credit_d = credit_q - 1'b1;
        else if (!accept && credit_return_i && credit_q != rv_core_pkg::RESULT_CREDITS)
            credit_d = credit_q + 1'b1;   // Saturates at the granted count
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credit_q <= rv_core_pkg::RESULT_CREDITS;
            pc_cnt_q <= '0;
            valid_q  <= 1'b0;
        end else begin
            credit_q <= credit_d;
            valid_q  <= accept;
            if (accept) pc_cnt_q <= pc_cnt_q + rv_core_pkg::PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr_i;
            pc_q    <= pc_cnt_q;
        end
    end

    // ==================================================
    // Field and immediate decode
    // ==================================================
    assign opcode = rv_core_pkg::opcode_e'(
                        instr_q[rv_core_pkg::OPCODE_LSB +: rv_core_pkg::OPCODE_W]);
    assign funct3 = instr_q[rv_core_pkg::FUNCT3_LSB +: rv_core_pkg::FUNCT3_W];
    assign alt    = instr_q[rv_core_pkg::FUNCT7_B5];

    assign imm_i = {{(rv_core_pkg::XLEN - rv_core_pkg::IMM_I_W){instr_q[rv_core_pkg::XLEN-1]}},
                    instr_q[rv_core_pkg::IMM_I_LSB +: rv_core_pkg::IMM_I_W]};
    assign imm_u = {instr_q[rv_core_pkg::IMM_U_LSB +: rv_core_pkg::IMM_U_W],
                    {(rv_core_pkg::XLEN - rv_core_pkg::IMM_U_W){1'b0}}};

    always_comb begin
        case (funct3)
            rv_core_pkg::F3_ADD_SUB: alu_f3 = (alt && opcode == rv_core_pkg::OPC_OP) ?
                                              rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            rv_core_pkg::F3_SLL:     alu_f3 = rv_core_pkg::ALU_SLL;
            rv_core_pkg::F3_SLT:     alu_f3 = rv_core_pkg::ALU_SLT;
            rv_core_pkg::F3_SLTU:    alu_f3 = rv_core_pkg::ALU_SLTU;
            rv_core_pkg::F3_XOR:     alu_f3 = rv_core_pkg::ALU_XOR;
            rv_core_pkg::F3_SR:      alu_f3 = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            rv_core_pkg::F3_OR:      alu_f3 = rv_core_pkg::ALU_OR;
            rv_core_pkg::F3_AND:     alu_f3 = rv_core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        exe_o.alu_op  = rv_core_pkg::ALU_ADD;
        exe_o.src_a   = rv_core_pkg::SRC_A_REG;
        exe_o.use_imm = 1'b0;
        exe_o.illegal = 1'b0;
        exe_o.imm     = imm_i;
        case (opcode)
            rv_core_pkg::OPC_OP:     exe_o.alu_op = alu_f3;
            rv_core_pkg::OPC_OP_IMM: begin
                exe_o.alu_op  = alu_f3;
                exe_o.use_imm = 1'b1;
            end
            rv_core_pkg::OPC_LUI: begin
                exe_o.src_a   = rv_core_pkg::SRC_A_ZERO;
                exe_o.use_imm = 1'b1;
                exe_o.imm     = imm_u;
            end
            rv_core_pkg::OPC_AUIPC: begin
                exe_o.src_a   = rv_core_pkg::SRC_A_PC;
                exe_o.use_imm = 1'b1;
                exe_o.imm     = imm_u;
            end
            default: exe_o.illegal = 1'b1;
        endcase
    end

    assign exe_o.valid = valid_q;
    assign exe_o.pc    = pc_q;
    assign exe_o.rs1   = instr_q[rv_core_pkg::RS1_LSB +: rv_core_pkg::REG_ADDR_W];
    assign exe_o.rs2   = instr_q[rv_core_pkg::RS2_LSB +: rv_core_pkg::REG_ADDR_W];
    assign exe_o.rd    = exe_o.illegal ? '0 :
                         instr_q[rv_core_pkg::RD_LSB +: rv_core_pkg::REG_ADDR_W];

    reg_file reg_file_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (exe_o.rs1),
        .raddr2_i (exe_o.rs2),
        .rdata1_o (exe_o.rs1_data),
        .rdata2_o (exe_o.rs2_data),
        .wen_i    (wb_en_i),
        .waddr_i  (wb_rd_i),
        .wdata_i  (wb_data_i)
    );

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    dec_exe_if.exe                 dec_i,
    exe_res_if.exe                 res_o,
    input  logic                   wb_en_i,
    input  rv_core_pkg::reg_addr_t wb_rd_i,
    input  rv_core_pkg::word_t     wb_data_i
);

    logic                   valid_q;
    logic                   illegal_q;
    rv_core_pkg::alu_op_e   alu_op_q;
    rv_core_pkg::src_a_e    src_a_q;
    logic                   use_imm_q;
    rv_core_pkg::reg_addr_t rd_q, rs1_q, rs2_q;
    rv_core_pkg::word_t     rs1_data_q, rs2_data_q, imm_q, pc_q;
    rv_core_pkg::word_t     rs1_fwd, rs2_fwd;
    rv_core_pkg::word_t     op_a, op_b, alu_res;
    logic [rv_core_pkg::SHAMT_W-1:0] shamt;

    // ==================================================
    // Execute register
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) valid_q <= 1'b0;
        else          valid_q <= dec_i.valid;
    end

    always_ff @(posedge clk) begin
        illegal_q  <= dec_i.illegal;
        alu_op_q   <= dec_i.alu_op;
        src_a_q    <= dec_i.src_a;
        use_imm_q  <= dec_i.use_imm;
        rd_q       <= dec_i.rd;
        rs1_q      <= dec_i.rs1;
        rs2_q      <= dec_i.rs2;
        rs1_data_q <= dec_i.rs1_data;
        rs2_data_q <= dec_i.rs2_data;
        imm_q      <= dec_i.imm;
        pc_q       <= dec_i.pc;
    end

    // Forward from the result stage, x0 never forwarded
    assign rs1_fwd = (wb_en_i && wb_rd_i == rs1_q && rs1_q != '0) ? wb_data_i : rs1_data_q;
    assign rs2_fwd = (wb_en_i && wb_rd_i == rs2_q && rs2_q != '0) ? wb_data_i : rs2_data_q;

    always_comb begin
        case (src_a_q)
            rv_core_pkg::SRC_A_REG: op_a = rs1_fwd;
            rv_core_pkg::SRC_A_PC:  op_a = pc_q;       // AUIPC
            default:                op_a = '0;         // LUI
        endcase
    end

    assign op_b  = use_imm_q ? imm_q : rs2_fwd;
    assign shamt = op_b[rv_core_pkg::SHAMT_W-1:0];

    // ==================================================
    // ALU
    // ==================================================
    always_comb begin
        case (alu_op_q)
            rv_core_pkg::ALU_ADD:  alu_res = op_a + op_b;
            rv_core_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rv_core_pkg::ALU_SLL:  alu_res = op_a << shamt;
            rv_core_pkg::ALU_SLT:  alu_res = rv_core_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_core_pkg::ALU_SLTU: alu_res = rv_core_pkg::word_t'(op_a < op_b);
            rv_core_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv_core_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            rv_core_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            rv_core_pkg::ALU_OR:   alu_res = op_a | op_b;
            default:               alu_res = op_a & op_b;
        endcase
    end

    assign res_o.valid   = valid_q;
    assign res_o.illegal = illegal_q;
    assign res_o.rd      = rd_q;
    assign res_o.data    = illegal_q ? '0 : alu_res;   // Illegal reports zero

endmodule

/* logic/result_stage.sv */
`timescale 1ns/1ps

module result_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    exe_res_if.res                 exe_i,
    output logic                   res_valid_o,
    output rv_core_pkg::reg_addr_t res_rd_o,
    output rv_core_pkg::word_t     res_data_o,
    output logic                   res_illegal_o,
    output logic                   wb_en_o,
    output rv_core_pkg::reg_addr_t wb_rd_o,
    output rv_core_pkg::word_t     wb_data_o
);

    logic                   valid_q;
    logic                   illegal_q;
    rv_core_pkg::reg_addr_t rd_q;
    rv_core_pkg::word_t     data_q;

    // ==================================================
    // Result register
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) valid_q <= 1'b0;
        else          valid_q <= exe_i.valid;
    end

    always_ff @(posedge clk) begin
        illegal_q <= exe_i.illegal;
        rd_q      <= exe_i.rd;
        data_q    <= exe_i.data;
    end

    // Output record, one cycle per result
    assign res_valid_o   = valid_q;
    assign res_rd_o      = rd_q;
    assign res_data_o    = data_q;
    assign res_illegal_o = illegal_q;

    // Register write, legal records with a real destination only
    assign wb_en_o   = valid_q && !illegal_q && (rd_q != '0);
    assign wb_rd_o   = rd_q;
    assign wb_data_o = data_q;

endmodule

/* logic/rv_int_pipe.sv */
`timescale 1ns/1ps

module rv_int_pipe (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // Instruction stream
    input  logic                   instr_valid_i,
    input  rv_core_pkg::word_t     instr_i,
    output logic                   instr_ready_o,

    // Result record
    output logic                   res_valid_o,
    output rv_core_pkg::reg_addr_t res_rd_o,
    output rv_core_pkg::word_t     res_data_o,
    output logic                   res_illegal_o,

    input  logic                   credit_return_i   // One per drained result
);

    dec_exe_if dec_exe ();
    exe_res_if exe_res ();

    // Write-back path
    logic                   wb_en;
    rv_core_pkg::reg_addr_t wb_rd;
    rv_core_pkg::word_t     wb_data;

    decode_stage decode_stage_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .credit_return_i (credit_return_i),
        .instr_ready_o   (instr_ready_o),
        .exe_o           (dec_exe),
        .wb_en_i         (wb_en),
        .wb_rd_i         (wb_rd),
        .wb_data_i       (wb_data)
    );

    execute_stage execute_stage_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .dec_i     (dec_exe),
        .res_o     (exe_res),
        .wb_en_i   (wb_en),
        .wb_rd_i   (wb_rd),
        .wb_data_i (wb_data)
    );

    result_stage result_stage_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .exe_i         (exe_res),
        .res_valid_o   (res_valid_o),
        .res_rd_o      (res_rd_o),
        .res_data_o    (res_data_o),
        .res_illegal_o (res_illegal_o),
        .wb_en_o       (wb_en),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

endmodule

/* sim/tb_rv_int_pipe.sv */
`timescale 1ns/1ps

module tb_rv_int_pipe;

    localparam int NUM_PATTERNS = 36;
    localparam int PAT_WORDS    = 4;                      // Instr, rd, data, illegal
    localparam int FULL_CREDITS = 4;
    localparam int TIMEOUT_CYC  = NUM_PATTERNS * 40 + 200;

    logic        clk;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        instr_ready_o;
    logic        res_valid_o;
    logic [4:0]  res_rd_o;
    logic [31:0] res_data_o;
    logic        res_illegal_o;
    logic        credit_return_i;

    logic [31:0] pat_mem [0:NUM_PATTERNS*PAT_WORDS-1];
    int          due_q[$];      // Sample cycle of each result in flight
    int          return_q[$];   // Cycles that hand a credit back
    int          errors;
    int          cyc;
    int          sent;
    int          seen;
    int          returned;
    int          credits;       // Model of the DUT credit counter
    int          last_return;
    logic [31:0] rng;
    logic        ready_seen;
    bit          first_return;

    rv_int_pipe rv_int_pipe_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .instr_ready_o   (instr_ready_o),
        .res_valid_o     (res_valid_o),
        .res_rd_o        (res_rd_o),
        .res_data_o      (res_data_o),
        .res_illegal_o   (res_illegal_o),
        .credit_return_i (credit_return_i)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One clock cycle, all work done at the falling edge
    task automatic step_cycle();
        int  slot;
        int  when;
        bit  idle;
        @(negedge clk);
        cyc++;

        // What the last rising edge took in
        if (instr_valid_i && ready_seen) begin
            sent++;
            credits--;
            due_q.push_back(cyc + 2);   // Visible after edge t+2
        end
        if (credit_return_i) credits++;
        compare("instr_ready_o", 32'(instr_ready_o), 32'(credits != 0));

        // Result monitor
        if (res_valid_o) begin
            if (due_q.size() == 0) begin
                errors++;
                $display("Result at time %0t with no instruction in flight", $time);
            end else begin
                slot = seen * PAT_WORDS;
                compare($sformatf("pattern %0d cycle", seen), cyc, due_q.pop_front());
                compare($sformatf("pattern %0d rd", seen), 32'(res_rd_o), pat_mem[slot + 1]);
                compare($sformatf("pattern %0d data", seen), res_data_o, pat_mem[slot + 2]);
                compare($sformatf("pattern %0d illegal", seen), 32'(res_illegal_o),
                        pat_mem[slot + 3]);
                seen++;
                rng  = xorshift32(rng);
                when = cyc + 1 + int'(rng % 32'd6);
                if (when <= last_return) when = last_return + 1;   // One credit per cycle
                last_return = when;
                return_q.push_back(when);
            end
        end else if (due_q.size() != 0 && due_q[0] == cyc) begin
            errors++;
            $display("Result for pattern %0d did not appear at time %0t", seen, $time);
            void'(due_q.pop_front());
            seen++;
        end
        if (seen - returned > FULL_CREDITS) begin
            errors++;
            $display("DUT presented %0d results against %0d granted slots",
                     seen - returned, FULL_CREDITS);
        end

        // Credit returner
        credit_return_i = 1'b0;
        if (return_q.size() != 0 && return_q[0] == cyc) begin
            void'(return_q.pop_front());
            credit_return_i = 1'b1;
            returned++;
            if (!first_return) begin
                first_return = 1'b1;
                compare("accepts before first credit", sent, FULL_CREDITS);
            end
        end

        // Next instruction, no idles until the first credits are used up
        ready_seen    = instr_ready_o;
        rng           = xorshift32(rng);
        idle          = (sent >= FULL_CREDITS) && (rng[1:0] == 2'b00);
        instr_valid_i = 1'b0;
        if (instr_ready_o && sent < NUM_PATTERNS && !idle) begin
            instr_valid_i = 1'b1;
            instr_i       = pat_mem[sent * PAT_WORDS];
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        errors          = 0;
        cyc             = 0;
        sent            = 0;
        seen            = 0;
        returned        = 0;
        credits         = FULL_CREDITS;
        last_return     = 0;
        first_return    = 1'b0;
        ready_seen      = 1'b0;
        rng             = 32'd29233;
        rst_n_i         = 1'b0;
        instr_valid_i   = 1'b0;
        instr_i         = '0;
        credit_return_i = 1'b0;
        $readmemh("sim/int_pipe_patterns.hex", pat_mem);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        compare("res_valid_o after reset", 32'(res_valid_o), 32'd0);
        compare("instr_ready_o after reset", 32'(instr_ready_o), 32'd1);

        while (seen < NUM_PATTERNS) begin
            step_cycle();
        end
        repeat (8) begin
            step_cycle();   // No stray results after the last one
        end

        $display("Errors: %0d, results checked: %0d of %0d", errors, seen, NUM_PATTERNS);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout after %0d cycles, only %0d of %0d results seen",
                 TIMEOUT_CYC, seen, NUM_PATTERNS);
        $display("Errors: %0d", errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* sim/int_pipe_patterns.hex */
// Columns: instruction word, expected rd, expected data, expected illegal flag
// One pattern per line in issue order, pattern n runs at PC 4*n
00500093 01 00000005 0  // addi x1, x0, 5
FFD00113 02 FFFFFFFD 0  // addi x2, x0, -3
002081B3 03 00000002 0  // add x3, x1, x2
40208233 04 00000008 0  // sub x4, x1, x2
401102B3 05 FFFFFFF8 0  // sub x5, x2, x1
4012D313 06 FFFFFFFC 0  // srai x6, x5, 1
01C2D393 07 0000000F 0  // srli x7, x5, 28
00409413 08 00000050 0  // slli x8, x1, 4
001124B3 09 00000001 0  // slt x9, x2, x1
00113533 0A 00000000 0  // sltu x10, x2, x1
FFF0C593 0B FFFFFFFA 0  // xori x11, x1, -1
0300E613 0C 00000035 0  // ori x12, x1, 0x30
0F017693 0D 000000F0 0  // andi x13, x2, 0xf0
12345737 0E 12345000 0  // lui x14, 0x12345
00001797 0F 00001038 0  // auipc x15, 0x1
67870713 0E 12345678 0  // addi x14, x14, 0x678
00D74833 10 12345688 0  // xor x16, x14, x13
0083E8B3 11 0000005F 0  // or x17, x7, x8
0012D933 12 07FFFFFF 0  // srl x18, x5, x1
4012D9B3 13 FFFFFFFF 0  // sra x19, x5, x1
00109A33 14 000000A0 0  // sll x20, x1, x1
FF92AA93 15 00000001 0  // slti x21, x5, -7
FFF0BB13 16 00000001 0  // sltiu x22, x1, -1
00A0A103 00 00000000 1  // lw x2, 10(x1), not supported
00708013 00 0000000C 0  // addi x0, x1, 7
00200BB3 17 FFFFFFFD 0  // add x23, x0, x2
00100C13 18 00000001 0  // addi x24, x0, 1
10000C93 19 00000100 0  // addi x25, x0, 0x100
001C8D13 1A 00000101 0  // addi x26, x25, 1
002C8D93 1B 00000102 0  // addi x27, x25, 2
003C8E13 1C 00000103 0  // addi x28, x25, 3
01BE0EB3 1D 00000205 0  // add x29, x28, x27
41AE8F33 1E 00000104 0  // sub x30, x29, x26
FFFFFF97 1F FFFFF084 0  // auipc x31, 0xfffff
800000B7 01 80000000 0  // lui x1, 0x80000
41F0D113 02 FFFFFFFF 0  // srai x2, x1, 31

/* rv_int_pipe.f */
logic/rv_core_pkg.sv
logic/pipe_if.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/rv_int_pipe.sv
sim/tb_rv_int_pipe.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       = tb_rv_int_pipe
FILELIST  = rv_int_pipe.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# Build and run, status follows the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /\*\* PASS \*\*/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
